/* list.f */
rtl/umi_pkg.sv
rtl/tl_pkg.sv
rtl/mask_convert.sv
rtl/req_queue.sv
rtl/write_ack_counter.sv
rtl/resp_format.sv
rtl/tl2umi_ctrl.sv
rtl/tl2umi.sv
sim/tb_tl2umi.sv

/* rtl/mask_convert.sv */
/*
 * Maskless conversion of a TileLink A beat. Derives the
 * UMI address, length and shifted data from the byte mask
 * and builds the user-defined source address.
 */

`timescale 1ns/1ps

module mask_convert
    import umi_pkg::*;
    import tl_pkg::*;
(
    input  logic        clk,
    input  logic        tl_a_valid,
    input  logic        tl_a_ready,
    input  tl_addr_t    tl_a_address,
    input  tl_mask_t    tl_a_mask,
    input  tl_data_t    tl_a_data,
    input  tl_size_t    tl_a_size,
    input  tl_source_t  tl_a_source,
    input  umi_chipid_t chipid,
    output umi_addr_t   dst_addr,
    output umi_addr_t   src_addr,
    output umi_data_t   shifted_data,
    output umi_len_t    put_len
);

    logic [2:0] first_one;
    logic [3:0] ones;

    // Lowest set mask bit wins
    always_comb begin
        first_one = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (tl_a_mask[i]) begin
                first_one = 3'(i);
            end
        end
    end

    always_comb begin
        ones = 4'd0;
        for (int i = 0; i < 8; i++) begin
            ones = ones + {3'b000, tl_a_mask[i]};
        end
    end

    assign put_len = {4'b0000, ones} - 8'd1;

    // Held for the push one cycle after the beat
    always_ff @(posedge clk) begin
        if (tl_a_valid && tl_a_ready) begin
            dst_addr     <= {8'b0, tl_a_address[55:3], first_one};
            src_addr     <= (umi_addr_t'(chipid) << SRC_CHIPID_LSB)
                          | (umi_addr_t'(first_one) << SRC_SHIFT_LSB)
                          | (umi_addr_t'(tl_a_size) << SRC_SIZE_LSB)
                          | (umi_addr_t'(tl_a_source) << SRC_SOURCE_LSB);
            shifted_data <= tl_a_data >> {first_one, 3'b000};
        end
    end

endmodule

/* rtl/req_queue.sv */
/*
 * UMI request queue. Packs the command word and holds
 * requests in a circular buffer until the host port
 * takes them, oldest first.
 */

`timescale 1ns/1ps

module req_queue
    import umi_pkg::*;
#(
    parameter int REQ_DEPTH = 2
) (
    input  logic        clk,
    input  logic        nreset,
    input  logic        push,
    input  umi_opcode_t req_opcode,
    input  umi_len_t    req_len,
    input  umi_addr_t   dst_addr,
    input  umi_addr_t   src_addr,
    input  umi_data_t   data,
    input  logic        uhost_req_ready,
    output logic        full,
    output logic        uhost_req_valid,
    output umi_cmd_t    uhost_req_cmd,
    output umi_addr_t   uhost_req_dstaddr,
    output umi_addr_t   uhost_req_srcaddr,
    output umi_data_t   uhost_req_data
);

    localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);

    umi_cmd_t   cmd_mem  [REQ_DEPTH];
    umi_addr_t  dst_mem  [REQ_DEPTH];
    umi_addr_t  src_mem  [REQ_DEPTH];
    umi_data_t  data_mem [REQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    umi_cmd_t         wr_cmd;
    logic             wr_en;
    logic             rd_en;

    // Size 0, eom set, everything else zero
    assign wr_cmd = {9'b0, 1'b1, 6'b0, req_len, 3'b000, req_opcode};

    assign full            = (count == CNT_W'(REQ_DEPTH));
    assign uhost_req_valid = (count != '0);
    assign wr_en           = push & ~full;
    assign rd_en           = uhost_req_valid & uhost_req_ready;

    assign uhost_req_cmd     = cmd_mem[rd_ptr];
    assign uhost_req_dstaddr = dst_mem[rd_ptr];
    assign uhost_req_srcaddr = src_mem[rd_ptr];
    assign uhost_req_data    = data_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            cmd_mem[wr_ptr]  <= wr_cmd;
            dst_mem[wr_ptr]  <= dst_addr;
            src_mem[wr_ptr]  <= src_addr;
            data_mem[wr_ptr] <= data;
        end
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* rtl/resp_format.sv */
/*
 * TileLink D-channel output register. Restores size and
 * source from the response address and realigns read
 * data by the stored first-one index.
 */

`timescale 1ns/1ps

module resp_format
    import umi_pkg::*;
    import tl_pkg::*;
(
    input  logic       clk,
    input  logic       nreset,
    input  logic       load_read,
    input  logic       load_write,
    input  umi_addr_t  resp_dstaddr,
    input  umi_data_t  resp_data,
    input  logic       tl_d_ready,
    output logic       tl_d_valid,
    output tl_opcode_t tl_d_opcode,
    output tl_size_t   tl_d_size,
    output tl_source_t tl_d_source,
    output tl_data_t   tl_d_data,
    output logic       d_busy
);

    logic [3:0] shift;

    assign shift  = resp_dstaddr[SRC_SHIFT_LSB +: 4];
    assign d_busy = tl_d_valid;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            tl_d_valid <= 1'b0;
        end else if (load_read || load_write) begin
            tl_d_valid <= 1'b1;
        end else if (tl_d_ready) begin
            tl_d_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_read || load_write) begin
            tl_d_opcode <= load_read ? TL_ACCESS_ACK_DATA : TL_ACCESS_ACK;
            tl_d_size   <= resp_dstaddr[SRC_SIZE_LSB +: 3];
            tl_d_source <= resp_dstaddr[SRC_SOURCE_LSB +: 5];
        end
        // Read data back to its byte lanes
        if (load_read) begin
            tl_d_data <= resp_data << {shift, 3'b000};
        end
    end

endmodule

/* rtl/tl2umi.sv */
/*
 * TileLink-UH to UMI host bridge, top level.
 * Wires the controller, maskless converter, request
 * queue, write ack counter and D-channel formatter.
 */

`timescale 1ns/1ps

module tl2umi
    import umi_pkg::*;
    import tl_pkg::*;
#(
    parameter int REQ_DEPTH = 2
) (
    input  logic        clk,
    input  logic        nreset,
    input  umi_chipid_t chipid,

    input  logic        tl_a_valid,
    input  tl_opcode_t  tl_a_opcode,
    input  tl_size_t    tl_a_size,
    input  tl_source_t  tl_a_source,
    input  tl_addr_t    tl_a_address,
    input  tl_mask_t    tl_a_mask,
    input  tl_data_t    tl_a_data,
    output logic        tl_a_ready,

    output logic        tl_d_valid,
    output tl_opcode_t  tl_d_opcode,
    output tl_size_t    tl_d_size,
    output tl_source_t  tl_d_source,
    output tl_data_t    tl_d_data,
    input  logic        tl_d_ready,

    output logic        uhost_req_valid,
    output umi_cmd_t    uhost_req_cmd,
    output umi_addr_t   uhost_req_dstaddr,
    output umi_addr_t   uhost_req_srcaddr,
    output umi_data_t   uhost_req_data,
    input  logic        uhost_req_ready,

    input  logic        uhost_resp_valid,
    input  umi_cmd_t    uhost_resp_cmd,
    input  umi_addr_t   uhost_resp_dstaddr,
    input  umi_data_t   uhost_resp_data,
    output logic        uhost_resp_ready
);

    logic        push;
    logic        full;
    umi_opcode_t req_opcode;
    umi_len_t    req_len;
    umi_len_t    put_len;
    umi_addr_t   dst_addr;
    umi_addr_t   src_addr;
    umi_data_t   shifted_data;
    logic        load_read;
    logic        load_write;
    logic        count_start;
    logic        count_add;
    logic        count_done;
    logic        d_busy;

    tl2umi_ctrl ctrl (
        .clk              (clk),
        .nreset           (nreset),
        .tl_a_valid       (tl_a_valid),
        .tl_a_opcode      (tl_a_opcode),
        .tl_a_size        (tl_a_size),
        .put_len          (put_len),
        .full             (full),
        .count_done       (count_done),
        .d_busy           (d_busy),
        .uhost_resp_valid (uhost_resp_valid),
        .uhost_resp_cmd   (uhost_resp_cmd),
        .tl_a_ready       (tl_a_ready),
        .push             (push),
        .req_opcode       (req_opcode),
        .req_len          (req_len),
        .uhost_resp_ready (uhost_resp_ready),
        .load_read        (load_read),
        .load_write       (load_write),
        .count_start      (count_start),
        .count_add        (count_add)
    );

    mask_convert conv (
        .clk          (clk),
        .tl_a_valid   (tl_a_valid),
        .tl_a_ready   (tl_a_ready),
        .tl_a_address (tl_a_address),
        .tl_a_mask    (tl_a_mask),
        .tl_a_data    (tl_a_data),
        .tl_a_size    (tl_a_size),
        .tl_a_source  (tl_a_source),
        .chipid       (chipid),
        .dst_addr     (dst_addr),
        .src_addr     (src_addr),
        .shifted_data (shifted_data),
        .put_len      (put_len)
    );

    req_queue #(
        .REQ_DEPTH (REQ_DEPTH)
    ) queue (
        .clk               (clk),
        .nreset            (nreset),
        .push              (push),
        .req_opcode        (req_opcode),
        .req_len           (req_len),
        .dst_addr          (dst_addr),
        .src_addr          (src_addr),
        .data              (shifted_data),
        .uhost_req_ready   (uhost_req_ready),
        .full              (full),
        .uhost_req_valid   (uhost_req_valid),
        .uhost_req_cmd     (uhost_req_cmd),
        .uhost_req_dstaddr (uhost_req_dstaddr),
        .uhost_req_srcaddr (uhost_req_srcaddr),
        .uhost_req_data    (uhost_req_data)
    );

    // Byte count target is len plus one
    write_ack_counter ack_cnt (
        .clk         (clk),
        .nreset      (nreset),
        .count_start (count_start),
        .target      (req_len + 8'd1),
        .count_add   (count_add),
        .resp_cmd    (uhost_resp_cmd),
        .count_done  (count_done)
    );

    resp_format fmt (
        .clk          (clk),
        .nreset       (nreset),
        .load_read    (load_read),
        .load_write   (load_write),
        .resp_dstaddr (uhost_resp_dstaddr),
        .resp_data    (uhost_resp_data),
        .tl_d_ready   (tl_d_ready),
        .tl_d_valid   (tl_d_valid),
        .tl_d_opcode  (tl_d_opcode),
        .tl_d_size    (tl_d_size),
        .tl_d_source  (tl_d_source),
        .tl_d_data    (tl_d_data),
        .d_busy       (d_busy)
    );

endmodule

/* rtl/tl2umi_ctrl.sv */
/*
 * Transaction FSM of the bridge. Accepts one A beat,
 * pushes the request, decodes UMI responses and
 * waits for the D beat to leave.
 */

`timescale 1ns/1ps

module tl2umi_ctrl
    import umi_pkg::*;
    import tl_pkg::*;
(
    input  logic        clk,
    input  logic        nreset,
    input  logic        tl_a_valid,
    input  tl_opcode_t  tl_a_opcode,
    input  tl_size_t    tl_a_size,
    input  umi_len_t    put_len,
    input  logic        full,
    input  logic        count_done,
    input  logic        d_busy,
    input  logic        uhost_resp_valid,
    input  umi_cmd_t    uhost_resp_cmd,
    output logic        tl_a_ready,
    output logic        push,
    output umi_opcode_t req_opcode,
    output umi_len_t    req_len,
    output logic        uhost_resp_ready,
    output logic        load_read,
    output logic        load_write,
    output logic        count_start,
    output logic        count_add
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PUSH,
        ST_WAIT_RESP,
        ST_WAIT_D
    } state_t;

    state_t      state;
    logic        a_accept;
    logic        resp_accept;
    umi_opcode_t resp_opcode;
    logic        resp_eom;
    umi_len_t    get_len;

    assign a_accept    = tl_a_valid & tl_a_ready;
    assign resp_accept = uhost_resp_valid & uhost_resp_ready & (state == ST_WAIT_RESP);
    assign resp_opcode = uhost_resp_cmd[CMD_OPCODE_LSB +: 5];
    assign resp_eom    = uhost_resp_cmd[CMD_EOM_BIT];
    assign get_len     = (8'd1 << tl_a_size) - 8'd1;

    assign push        = (state == ST_PUSH);
    assign count_start = push & ~full;
    assign count_add   = resp_accept & (resp_opcode == UMI_RESP_WRITE);
    assign load_read   = resp_accept & (resp_opcode == UMI_RESP_READ) & resp_eom;
    // Partial write acks are absorbed by the counter
    assign load_write  = count_add & count_done;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            state            <= ST_IDLE;
            tl_a_ready       <= 1'b0;
            uhost_resp_ready <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    tl_a_ready       <= ~a_accept;
                    uhost_resp_ready <= 1'b1;
                    if (a_accept) begin
                        state <= ST_PUSH;
                    end
                end
                ST_PUSH: begin
                    if (!full) begin
                        state <= ST_WAIT_RESP;
                    end
                end
                ST_WAIT_RESP: begin
                    if (load_read || load_write) begin
                        state            <= ST_WAIT_D;
                        uhost_resp_ready <= 1'b0;
                    end
                end
                ST_WAIT_D: begin
                    if (!d_busy) begin
                        state            <= ST_IDLE;
                        tl_a_ready       <= 1'b1;
                        uhost_resp_ready <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request fields captured with the A beat
    always_ff @(posedge clk) begin
        if (a_accept) begin
            case (tl_a_opcode)
                TL_PUT_FULL, TL_PUT_PARTIAL: begin
                    req_opcode <= UMI_REQ_WRITE;
                    req_len    <= put_len;
                end
                default: begin
                    req_opcode <= UMI_REQ_READ;
                    req_len    <= get_len;
                end
            endcase
        end
    end

endmodule

/* rtl/tl_pkg.sv */
/*
 * TileLink-UH field types and the A/D channel
 * opcodes used by the bridge
 */

package tl_pkg;

    typedef logic [2:0]  tl_opcode_t;
    typedef logic [2:0]  tl_size_t;
    typedef logic [4:0]  tl_source_t;
    typedef logic [55:0] tl_addr_t;
    typedef logic [7:0]  tl_mask_t;
    typedef logic [63:0] tl_data_t;

    // A channel
    localparam tl_opcode_t TL_PUT_FULL    = 3'd0;
    localparam tl_opcode_t TL_PUT_PARTIAL = 3'd1;
    localparam tl_opcode_t TL_GET         = 3'd4;

    // D channel
    localparam tl_opcode_t TL_ACCESS_ACK      = 3'd0;
    localparam tl_opcode_t TL_ACCESS_ACK_DATA = 3'd1;

endpackage

/* rtl/umi_pkg.sv */
/*
 * UMI field types, request and response opcodes,
 * command word bit positions and the layout of the
 * user-defined source address
 */

package umi_pkg;

    typedef logic [31:0] umi_cmd_t;
    typedef logic [63:0] umi_addr_t;
    typedef logic [63:0] umi_data_t;
    typedef logic [7:0]  umi_len_t;
    typedef logic [4:0]  umi_opcode_t;
    typedef logic [2:0]  umi_size_t;
    typedef logic [23:0] umi_chipid_t;

    localparam umi_opcode_t UMI_REQ_READ   = 5'd1;
    localparam umi_opcode_t UMI_RESP_READ  = 5'd2;
    localparam umi_opcode_t UMI_REQ_WRITE  = 5'd3;
    localparam umi_opcode_t UMI_RESP_WRITE = 5'd4;

    // Command word fields
    localparam int CMD_OPCODE_LSB = 0;
    localparam int CMD_SIZE_LSB   = 5;
    localparam int CMD_LEN_LSB    = 8;
    localparam int CMD_EOM_BIT    = 22;

    // Source address layout
    // 63:40 chip id, 35:32 first-one index, 26:24 TL size, 20:16 TL source
    localparam int SRC_SOURCE_LSB = 16;
    localparam int SRC_SIZE_LSB   = 24;
    localparam int SRC_SHIFT_LSB  = 32;
    localparam int SRC_CHIPID_LSB = 40;

endpackage

/* rtl/write_ack_counter.sv */
/*
 * Running byte count of UMI write responses,
 * flags the response that reaches the target
 */

`timescale 1ns/1ps

module write_ack_counter
    import umi_pkg::*;
(
    input  logic     clk,
    input  logic     nreset,
    input  logic     count_start,
    input  umi_len_t target,
    input  logic     count_add,
    input  umi_cmd_t resp_cmd,
    output logic     count_done
);

    umi_size_t   resp_size;
    umi_len_t    resp_len;
    logic [15:0] resp_bytes;
    logic [15:0] sum;
    umi_len_t    target_q;

    assign resp_size  = resp_cmd[CMD_SIZE_LSB +: 3];
    assign resp_len   = resp_cmd[CMD_LEN_LSB +: 8];
    // (len + 1) words of 2^size bytes
    assign resp_bytes = ({8'b0, resp_len} + 16'd1) << resp_size;
    assign count_done = count_add & ((sum + resp_bytes) == {8'b0, target_q});

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            sum      <= '0;
            target_q <= '0;
        end else if (count_start) begin
            sum      <= '0;
            target_q <= target;
        end else if (count_add) begin
            sum <= sum + resp_bytes;
        end
    end

endmodule

/* sim/tb_tl2umi.sv */
/*
 * Directed testbench for the TileLink-UH to UMI bridge.
 * Galois LFSR stimulus, behavioral UMI responder,
 * typed compare tasks, five tests and a cycle watchdog.
 */

`timescale 1ns/1ps

module tb_tl2umi
    import umi_pkg::*;
    import tl_pkg::*;
();

    localparam int          REQ_DEPTH      = 2;
    localparam umi_chipid_t CHIPID         = 24'h00A5C3;
    localparam int          NUM_TESTS      = 5;
    localparam int          TIMEOUT_CYCLES = 20 * NUM_TESTS;

    logic        clk;
    logic        nreset;

    logic        tl_a_valid;
    tl_opcode_t  tl_a_opcode;
    tl_size_t    tl_a_size;
    tl_source_t  tl_a_source;
    tl_addr_t    tl_a_address;
    tl_mask_t    tl_a_mask;
    tl_data_t    tl_a_data;
    logic        tl_a_ready;

    logic        tl_d_valid;
    tl_opcode_t  tl_d_opcode;
    tl_size_t    tl_d_size;
    tl_source_t  tl_d_source;
    tl_data_t    tl_d_data;
    logic        tl_d_ready;

    logic        uhost_req_valid;
    umi_cmd_t    uhost_req_cmd;
    umi_addr_t   uhost_req_dstaddr;
    umi_addr_t   uhost_req_srcaddr;
    umi_data_t   uhost_req_data;
    logic        uhost_req_ready;

    logic        uhost_resp_valid;
    umi_cmd_t    uhost_resp_cmd;
    umi_addr_t   uhost_resp_dstaddr;
    umi_data_t   uhost_resp_data;
    logic        uhost_resp_ready;

    // Last request and D beat seen
    umi_cmd_t    req_cmd;
    umi_addr_t   req_dst;
    umi_addr_t   req_src;
    umi_data_t   req_data;
    tl_opcode_t  d_opcode;
    tl_size_t    d_size;
    tl_source_t  d_source;
    tl_data_t    d_data;

    logic [15:0] lfsr_state;
    int          cycle_count = 0;
    int          error_count = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       test_name;

    tl2umi #(
        .REQ_DEPTH (REQ_DEPTH)
    ) UUT (
        .clk                (clk),
        .nreset             (nreset),
        .chipid             (CHIPID),
        .tl_a_valid         (tl_a_valid),
        .tl_a_opcode        (tl_a_opcode),
        .tl_a_size          (tl_a_size),
        .tl_a_source        (tl_a_source),
        .tl_a_address       (tl_a_address),
        .tl_a_mask          (tl_a_mask),
        .tl_a_data          (tl_a_data),
        .tl_a_ready         (tl_a_ready),
        .tl_d_valid         (tl_d_valid),
        .tl_d_opcode        (tl_d_opcode),
        .tl_d_size          (tl_d_size),
        .tl_d_source        (tl_d_source),
        .tl_d_data          (tl_d_data),
        .tl_d_ready         (tl_d_ready),
        .uhost_req_valid    (uhost_req_valid),
        .uhost_req_cmd      (uhost_req_cmd),
        .uhost_req_dstaddr  (uhost_req_dstaddr),
        .uhost_req_srcaddr  (uhost_req_srcaddr),
        .uhost_req_data     (uhost_req_data),
        .uhost_req_ready    (uhost_req_ready),
        .uhost_resp_valid   (uhost_resp_valid),
        .uhost_resp_cmd     (uhost_resp_cmd),
        .uhost_resp_dstaddr (uhost_resp_dstaddr),
        .uhost_resp_data    (uhost_resp_data),
        .uhost_resp_ready   (uhost_resp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [63:0] random_bits(input int nbits);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = {value[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic int first_set(input tl_mask_t mask);
        int idx;
        idx = 0;
        while (idx < 7 && !mask[idx]) begin
            idx++;
        end
        return idx;
    endfunction

    function automatic umi_cmd_t expected_cmd(input umi_opcode_t op, input umi_len_t len);
        return umi_cmd_t'(op) | (umi_cmd_t'(len) << 8) | (umi_cmd_t'(1) << 22);
    endfunction

    function automatic umi_cmd_t make_resp_cmd(input umi_opcode_t op, input umi_size_t size,
                                               input umi_len_t len);
        return expected_cmd(op, len) | (umi_cmd_t'(size) << 5);
    endfunction

    function automatic umi_addr_t expected_dst(input tl_addr_t addr, input int first);
        return (umi_addr_t'(addr) & ~umi_addr_t'(7)) | umi_addr_t'(first);
    endfunction

    function automatic umi_addr_t expected_src(input tl_size_t size, input tl_source_t source,
                                               input int first);
        return (umi_addr_t'(CHIPID) << SRC_CHIPID_LSB)
             | (umi_addr_t'(first) << SRC_SHIFT_LSB)
             | (umi_addr_t'(size) << SRC_SIZE_LSB)
             | (umi_addr_t'(source) << SRC_SOURCE_LSB);
    endfunction

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    task automatic check_cmd(input umi_cmd_t got, input umi_cmd_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: expected %h, got %h", $time, what, exp, got);
            count_error();
        end
    endtask

    task automatic check_addr(input umi_addr_t got, input umi_addr_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: expected %h, got %h", $time, what, exp, got);
            count_error();
        end
    endtask

    task automatic check_data(input umi_data_t got, input umi_data_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: expected %h, got %h", $time, what, exp, got);
            count_error();
        end
    endtask

    task automatic check_opcode(input tl_opcode_t got, input tl_opcode_t exp,
                                input string what);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: expected %0d, got %0d", $time, what, exp, got);
            count_error();
        end
    endtask

    task automatic check_size(input tl_size_t got, input tl_size_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: expected %0d, got %0d", $time, what, exp, got);
            count_error();
        end
    endtask

    task automatic check_source(input tl_source_t got, input tl_source_t exp,
                                input string what);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: expected %0d, got %0d", $time, what, exp, got);
            count_error();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: expected %b, got %b", $time, what, exp, got);
            count_error();
        end
    endtask

    task automatic send_a(input tl_opcode_t opcode, input tl_size_t size,
                          input tl_source_t source, input tl_addr_t addr,
                          input tl_mask_t mask, input tl_data_t data);
        @(posedge clk);
        tl_a_valid   <= 1'b1;
        tl_a_opcode  <= opcode;
        tl_a_size    <= size;
        tl_a_source  <= source;
        tl_a_address <= addr;
        tl_a_mask    <= mask;
        tl_a_data    <= data;
        do begin
            @(negedge clk);
        end while (!tl_a_ready);
        @(posedge clk);
        tl_a_valid <= 1'b0;
    endtask

    task automatic capture_req();
        req_cmd  = uhost_req_cmd;
        req_dst  = uhost_req_dstaddr;
        req_src  = uhost_req_srcaddr;
        req_data = uhost_req_data;
    endtask

    task automatic capture_d();
        d_opcode = tl_d_opcode;
        d_size   = tl_d_size;
        d_source = tl_d_source;
        d_data   = tl_d_data;
    endtask

    task automatic take_req();
        do begin
            @(negedge clk);
        end while (!(uhost_req_valid && uhost_req_ready));
        capture_req();
        @(posedge clk);
    endtask

    task automatic take_d();
        do begin
            @(negedge clk);
        end while (!(tl_d_valid && tl_d_ready));
        capture_d();
        @(posedge clk);
    endtask

    // Responder echoes the request source address
    task automatic send_resp(input umi_cmd_t cmd, input umi_data_t data);
        @(posedge clk);
        uhost_resp_valid   <= 1'b1;
        uhost_resp_cmd     <= cmd;
        uhost_resp_dstaddr <= req_src;
        uhost_resp_data    <= data;
        do begin
            @(negedge clk);
        end while (!uhost_resp_ready);
        @(posedge clk);
        uhost_resp_valid <= 1'b0;
    endtask

    task automatic check_request(input umi_opcode_t op, input umi_len_t len,
                                 input tl_addr_t addr, input tl_mask_t mask,
                                 input tl_size_t size, input tl_source_t source,
                                 input tl_data_t a_data);
        int first;
        first = first_set(mask);
        check_cmd(req_cmd, expected_cmd(op, len), "request cmd");
        check_addr(req_dst, expected_dst(addr, first), "request dstaddr");
        check_addr(req_src, expected_src(size, source, first), "request srcaddr");
        if (op == UMI_REQ_WRITE) begin
            check_data(req_data, a_data >> (8 * first), "request data");
        end
    endtask

    task automatic check_d(input tl_opcode_t opcode, input tl_size_t size,
                           input tl_source_t source, input tl_data_t data);
        check_opcode(d_opcode, opcode, "d_opcode");
        check_size(d_size, size, "d_size");
        check_source(d_source, source, "d_source");
        if (opcode == TL_ACCESS_ACK_DATA) begin
            check_data(d_data, data, "d_data");
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: FAILED with %0d mismatches", test_name, test_errors);
        end
    endtask

    task automatic test_get_full();
        tl_addr_t   addr;
        tl_source_t source;
        umi_data_t  rdata;
        addr   = tl_addr_t'(random_bits(53)) << 3;
        source = tl_source_t'(random_bits(5));
        rdata  = random_bits(64);
        send_a(TL_GET, 3'd3, source, addr, 8'hFF, '0);
        take_req();
        check_request(UMI_REQ_READ, 8'd7, addr, 8'hFF, 3'd3, source, '0);
        send_resp(make_resp_cmd(UMI_RESP_READ, 3'd3, 8'd0), rdata);
        take_d();
        check_d(TL_ACCESS_ACK_DATA, 3'd3, source, rdata);
    endtask

    task automatic test_put_partial();
        tl_addr_t   addr;
        tl_source_t source;
        tl_data_t   wdata;
        addr   = tl_addr_t'(random_bits(53)) << 3;
        source = tl_source_t'(random_bits(5));
        wdata  = random_bits(64);
        send_a(TL_PUT_PARTIAL, 3'd3, source, addr, 8'b0011_1000, wdata);
        take_req();
        check_request(UMI_REQ_WRITE, 8'd2, addr, 8'b0011_1000, 3'd3, source, wdata);
        // One response of 3 bytes
        send_resp(make_resp_cmd(UMI_RESP_WRITE, 3'd0, 8'd2), '0);
        take_d();
        check_d(TL_ACCESS_ACK, 3'd3, source, '0);
    endtask

    task automatic test_get_upper();
        tl_addr_t   addr;
        tl_source_t source;
        umi_data_t  rdata;
        addr   = (tl_addr_t'(random_bits(53)) << 3) | tl_addr_t'(4);
        source = tl_source_t'(random_bits(5));
        rdata  = random_bits(64);
        send_a(TL_GET, 3'd2, source, addr, 8'hF0, '0);
        take_req();
        check_request(UMI_REQ_READ, 8'd3, addr, 8'hF0, 3'd2, source, '0);
        send_resp(make_resp_cmd(UMI_RESP_READ, 3'd2, 8'd0), rdata);
        take_d();
        check_d(TL_ACCESS_ACK_DATA, 3'd2, source, rdata << 32);
    endtask

    task automatic test_split_ack();
        tl_addr_t   addr;
        tl_source_t source;
        tl_data_t   wdata;
        addr   = tl_addr_t'(random_bits(53)) << 3;
        source = tl_source_t'(random_bits(5));
        wdata  = random_bits(64);
        send_a(TL_PUT_FULL, 3'd3, source, addr, 8'hFF, wdata);
        take_req();
        check_request(UMI_REQ_WRITE, 8'd7, addr, 8'hFF, 3'd3, source, wdata);
        // 4 bytes as one word of 4, then 4 words of 1
        send_resp(make_resp_cmd(UMI_RESP_WRITE, 3'd2, 8'd0), '0);
        @(negedge clk);
        check_bit(tl_d_valid, 1'b0, "D beat after first partial ack");
        send_resp(make_resp_cmd(UMI_RESP_WRITE, 3'd0, 8'd3), '0);
        take_d();
        check_d(TL_ACCESS_ACK, 3'd3, source, '0);
        repeat (3) begin
            @(negedge clk);
            check_bit(tl_d_valid, 1'b0, "extra D beat after AccessAck");
        end
    endtask

    task automatic test_backpressure();
        tl_addr_t   addr;
        tl_source_t source;
        tl_data_t   wdata;
        tl_mask_t   mask;
        umi_len_t   len;
        addr   = tl_addr_t'(random_bits(53)) << 3;
        source = tl_source_t'(random_bits(5));
        wdata  = random_bits(64);
        mask   = tl_mask_t'(random_bits(8));
        if (mask == '0) begin
            mask = 8'h80;
        end
        len = umi_len_t'($countones(mask) - 1);
        @(posedge clk);
        uhost_req_ready <= 1'b0;
        tl_d_ready      <= 1'b0;
        send_a(TL_PUT_PARTIAL, 3'd3, source, addr, mask, wdata);
        do begin
            @(negedge clk);
        end while (!uhost_req_valid);
        capture_req();
        repeat (4) begin
            @(negedge clk);
            check_bit(uhost_req_valid, 1'b1, "held uhost_req_valid");
            check_cmd(uhost_req_cmd, req_cmd, "held request cmd");
            check_addr(uhost_req_dstaddr, req_dst, "held request dstaddr");
            check_addr(uhost_req_srcaddr, req_src, "held request srcaddr");
            check_data(uhost_req_data, req_data, "held request data");
        end
        @(posedge clk);
        uhost_req_ready <= 1'b1;
        take_req();
        check_request(UMI_REQ_WRITE, len, addr, mask, 3'd3, source, wdata);
        send_resp(make_resp_cmd(UMI_RESP_WRITE, 3'd0, len), '0);
        do begin
            @(negedge clk);
        end while (!tl_d_valid);
        capture_d();
        repeat (4) begin
            @(negedge clk);
            check_bit(tl_d_valid, 1'b1, "held tl_d_valid");
            check_bit(tl_a_ready, 1'b0, "tl_a_ready while D pending");
            check_bit(uhost_resp_ready, 1'b0, "uhost_resp_ready while D pending");
            check_opcode(tl_d_opcode, d_opcode, "held d_opcode");
            check_size(tl_d_size, d_size, "held d_size");
            check_source(tl_d_source, d_source, "held d_source");
        end
        @(posedge clk);
        tl_d_ready <= 1'b1;
        take_d();
        check_d(TL_ACCESS_ACK, 3'd3, source, '0);
    endtask

    initial begin
        lfsr_state         = 16'd33725;
        nreset             = 1'b0;
        tl_a_valid         = 1'b0;
        tl_a_opcode        = '0;
        tl_a_size          = '0;
        tl_a_source        = '0;
        tl_a_address       = '0;
        tl_a_mask          = '0;
        tl_a_data          = '0;
        tl_d_ready         = 1'b1;
        uhost_req_ready    = 1'b1;
        uhost_resp_valid   = 1'b0;
        uhost_resp_cmd     = '0;
        uhost_resp_dstaddr = '0;
        uhost_resp_data    = '0;
        repeat (4) @(posedge clk);
        nreset <= 1'b1;

        start_test("get_full_mask");
        test_get_full();
        end_test();
        start_test("put_partial");
        test_put_partial();
        end_test();
        start_test("get_upper_bytes");
        test_get_upper();
        end_test();
        start_test("split_write_ack");
        test_split_ack();
        end_test();
        start_test("backpressure");
        test_backpressure();
        end_test();

        $display("Tests run: %0d, failed: %0d, mismatches: %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
